// ==== compile.f ====
design/uart_pkg.sv
design/uart_cmd_tx.sv
design/uart_frame_rx.sv
design/uart.sv
verif/tb_uart.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uart testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f compile.f --top-module tb_uart -o tb_uart
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_uart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message missing from $LOG"
exit 1

// ==== verif/tb_uart.sv ====
module tb_uart;

  localparam int CLK_HZ       = 1_600_000;
  localparam int BAUD         = 100_000;
  localparam int CPB          = CLK_HZ / BAUD;
  localparam int DW           = uart_pkg::DATA_BITS;
  localparam int FRAME_BITS   = DW + 3;
  localparam int FRAME_CYCLES = FRAME_BITS * CPB;
  localparam int BUSY_CYCLES  = uart_pkg::CMD_BYTES * FRAME_CYCLES;
  localparam int TIMEOUT      = 30 * FRAME_CYCLES + 500;

  logic                clk = 1'b0;
  logic                rst_n = 1'b0;
  uart_pkg::cmd_word_t cmd_in = '0;
  logic                cmd_vld = 1'b0;
  logic                cmd_rdy;
  logic                tx;
  logic                rx;
  logic                read_rdy;
  uart_pkg::rx_byte_t  read_data;

  // rx source select, loopback or driven line
  logic               use_loop = 1'b1;
  logic               drv_line = 1'b1;
  logic               idle_chk = 1'b0;
  logic               rdy_checked = 1'b0;
  int                 busy_cnt;
  int                 cycles = 0;
  int                 errors = 0;
  int                 test_errs = 0;
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;
  int                 exp_cnt = 0;
  string              test_name = "reset";
  uart_pkg::rx_byte_t exp_q[$];
  uart_pkg::rx_byte_t exp_head = '0;

  assign rx = use_loop ? tx : drv_line;

  uart #(
    .CLK_HZ    (CLK_HZ),
    .BAUD      (BAUD),
    .PARITY_EN (1)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always #5 clk = ~clk;

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  endfunction

  function automatic void expect_byte(input logic perr, input logic [DW-1:0] data);
    exp_q.push_back({perr, data});
    refresh_head();
  endfunction

  // pulse seen by the clock edge that compared it
  always @(posedge clk) begin
    rdy_checked <= rst_n && read_rdy;
  end

  // head retires on the falling edge after that compare
  always @(negedge clk) begin
    if (rdy_checked && exp_q.size() != 0) begin
      exp_q.delete(0);
      refresh_head();
    end
  end

  // length of the current low stretch of cmd_rdy
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_cnt <= 0;
    end else if (!cmd_rdy) begin
      busy_cnt <= busy_cnt + 1;
    end else begin
      busy_cnt <= 0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy && exp_cnt != 0 |-> read_data == exp_head)
    else begin
      $display("Mismatch in %s: expected %h, actual %h",
               test_name, exp_head, $sampled(read_data));
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> exp_cnt != 0)
    else begin
      $display("%s: read_rdy pulsed while no byte was expected", test_name);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> busy_cnt == BUSY_CYCLES)
    else begin
      $display("Mismatch in %s: expected busy %0d, actual %0d",
               test_name, BUSY_CYCLES, $sampled(busy_cnt));
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) busy_cnt <= BUSY_CYCLES + 2)
    else begin
      $display("%s: cmd_rdy stayed low too long", test_name);
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    idle_chk |-> tx && cmd_rdy && !read_rdy && read_data == '0)
    else begin
      $display("%s: idle outputs not at their reset values", test_name);
      errors++;
    end

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic end_test();
    if (errors == test_errs) begin
      pass_cnt++;
      $display("%s: pass", test_name);
    end else begin
      fail_cnt++;
      $display("%s: fail, %0d errors", test_name, errors - test_errs);
    end
  endtask

  task automatic send_cmd(input uart_pkg::cmd_word_t c);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < BUSY_CYCLES + 4) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      $display("%s: cmd_rdy never came back", test_name);
      errors++;
    end
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    expect_byte(1'b0, c.hi);
    expect_byte(1'b0, c.lo);
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // start, data lsb first, odd parity, stop
  task automatic send_frame(input logic [DW-1:0] data, input logic bad_par);
    logic [FRAME_BITS-1:0] bits;
    logic                  par;
    int                    ones;
    ones = 0;
    for (int i = 0; i < DW; i++) begin
      if (data[i]) begin
        ones++;
      end
    end
    par  = (ones % 2 == 0);
    bits = {1'b1, par ^ bad_par, data, 1'b0};
    for (int b = 0; b < FRAME_BITS; b++) begin
      @(posedge clk);
      drv_line <= bits[b];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_cnt != 0 && n < BUSY_CYCLES + 4 * CPB) begin
      @(posedge clk);
      n++;
    end
    if (exp_cnt != 0) begin
      $display("%s: %0d expected bytes never arrived", test_name, exp_cnt);
      errors++;
    end
  endtask

  initial begin
    logic [31:0] r;
    void'($urandom(32'h5988));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("reset_idle");
    idle_chk <= 1'b1;
    repeat (FRAME_CYCLES) @(posedge clk);
    idle_chk <= 1'b0;
    end_test();

    begin_test("single_cmd");
    send_cmd(16'hA55A);
    wait_drain();
    end_test();

    begin_test("random_cmds");
    repeat (8) begin
      r = $urandom;
      send_cmd(r[uart_pkg::CMD_WIDTH-1:0]);
    end
    wait_drain();
    end_test();

    begin_test("ignored_vld");
    send_cmd(16'h1234);
    repeat (5 * CPB) @(posedge clk);
    cmd_in  <= 16'hBEEF;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    wait_drain();
    // long enough for a queued frame to show up
    repeat (FRAME_CYCLES + 2 * CPB) @(posedge clk);
    end_test();

    begin_test("bad_parity");
    use_loop <= 1'b0;
    expect_byte(1'b1, 8'hC3);
    send_frame(8'hC3, 1'b1);
    wait_drain();
    end_test();

    // short low pulse must not start a frame
    begin_test("glitch");
    @(posedge clk);
    drv_line <= 1'b0;
    repeat (4) @(posedge clk);
    drv_line <= 1'b1;
    repeat (2 * CPB) @(posedge clk);
    expect_byte(1'b0, 8'h96);
    send_frame(8'h96, 1'b0);
    wait_drain();
    end_test();

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== design/uart.sv ====
module uart #(
  parameter int CLK_HZ    = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter int PARITY_EN = 1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::cmd_word_t cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                tx,
  input  logic                rx,
  output logic                read_rdy,
  output uart_pkg::rx_byte_t  read_data
);

  // command path, two frames per command
  uart_cmd_tx #(
    .CLK_HZ    (CLK_HZ),
    .BAUD      (BAUD),
    .PARITY_EN (PARITY_EN)
  ) i_cmd_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx      (tx)
  );

  // receive path, one pulse per byte
  uart_frame_rx #(
    .CLK_HZ    (CLK_HZ),
    .BAUD      (BAUD),
    .PARITY_EN (PARITY_EN)
  ) i_frame_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// ==== design/uart_frame_rx.sv ====
module uart_frame_rx #(
  parameter int CLK_HZ    = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter int PARITY_EN = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  output logic               read_rdy,
  output uart_pkg::rx_byte_t read_data
);

  localparam int DW             = uart_pkg::DATA_BITS;
  localparam int CYCLES_PER_BIT = CLK_HZ / BAUD;
  localparam int SAMPLE_W       = $clog2(CYCLES_PER_BIT + 1);
  localparam int IDX_W          = $clog2(DW);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } state_t;

  state_t              state;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic [SAMPLE_W-1:0] cnt;
  logic [IDX_W-1:0]    bit_idx;
  logic [DW-1:0]       shift_q;
  logic                par_q;
  logic                rx_fall;
  logic                half_tick;
  logic                bit_tick;
  logic                parity_err;

  assign rx_fall    = rx_prev & ~rx_sync;
  assign half_tick  = (cnt == SAMPLE_W'(CYCLES_PER_BIT / 2 - 1));
  assign bit_tick   = (cnt == SAMPLE_W'(CYCLES_PER_BIT - 1));
  assign parity_err = (PARITY_EN != 0) && (par_q != uart_pkg::odd_parity(shift_q));

  // two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cnt       <= '0;
      bit_idx   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      cnt      <= cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          cnt <= '0;
          if (rx_fall) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          // mid start bit, high here means a glitch
          if (half_tick) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? ST_IDLE : ST_DATA;
          end
        end
        ST_DATA: begin
          if (bit_tick) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(DW - 1)) begin
              state <= (PARITY_EN != 0) ? ST_PARITY : ST_STOP;
            end
          end
        end
        ST_PARITY: begin
          if (bit_tick) begin
            cnt   <= '0;
            state <= ST_STOP;
          end
        end
        ST_STOP: begin
          if (bit_tick) begin
            cnt   <= '0;
            state <= ST_IDLE;
            // bad stop bit drops the frame
            if (rx_sync) begin
              read_rdy             <= 1'b1;
              read_data.data       <= shift_q;
              read_data.parity_err <= parity_err;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // payload capture, lsb first
  always_ff @(posedge clk) begin
    if (state == ST_DATA && bit_tick) begin
      shift_q <= {rx_sync, shift_q[DW-1:1]};
    end
    if (state == ST_PARITY && bit_tick) begin
      par_q <= rx_sync;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy held for two cycles");

  assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> $past(state == ST_STOP))
    else $error("read_rdy raised outside the stop state");

endmodule

// ==== design/uart_cmd_tx.sv ====
module uart_cmd_tx #(
  parameter int CLK_HZ    = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter int PARITY_EN = 1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::cmd_word_t cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                tx
);

  localparam int DW             = uart_pkg::DATA_BITS;
  localparam int CW             = uart_pkg::CMD_WIDTH;
  localparam int NB             = uart_pkg::CMD_BYTES;
  localparam int FRAME_BITS     = DW + PARITY_EN + 2;
  localparam int CYCLES_PER_BIT = CLK_HZ / BAUD;
  localparam int BAUD_W         = $clog2(CYCLES_PER_BIT + 1);
  localparam int BIT_W          = $clog2(FRAME_BITS);
  localparam int BYTE_W         = (NB > 1) ? $clog2(NB) : 1;

  logic                  busy;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [BYTE_W-1:0]     byte_idx;
  logic [FRAME_BITS-2:0] frame_q;
  logic [CW-1:0]         cmd_q;
  logic [FRAME_BITS-1:0] first_frame;
  logic [FRAME_BITS-1:0] next_frame;
  logic                  accept;
  logic                  baud_tick;
  logic                  frame_end;
  logic                  last_byte;

  // start bit at lsb, stop bit at msb
  function automatic logic [FRAME_BITS-1:0] build_frame(
    input logic [DW-1:0] data
  );
    logic [FRAME_BITS-1:0] frame;
    frame         = '1;
    frame[0]      = 1'b0;
    frame[DW:1]   = data;
    if (PARITY_EN != 0) begin
      frame[DW+1] = uart_pkg::odd_parity(data);
    end
    return frame;
  endfunction

  assign accept      = cmd_vld & ~busy;
  assign baud_tick   = busy && (baud_cnt == BAUD_W'(CYCLES_PER_BIT - 1));
  assign frame_end   = baud_tick && (bit_cnt == BIT_W'(FRAME_BITS - 1));
  assign last_byte   = (byte_idx == BYTE_W'(NB - 1));
  assign cmd_rdy     = ~busy;
  assign first_frame = build_frame(cmd_in.hi);
  assign next_frame  = build_frame(cmd_q[CW-DW-1 -: DW]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_idx <= '0;
      tx       <= 1'b1;
    end else if (accept) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_idx <= '0;
      tx       <= 1'b0;
    end else if (busy) begin
      if (!baud_tick) begin
        baud_cnt <= baud_cnt + 1'b1;
      end else begin
        baud_cnt <= '0;
        if (!frame_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= frame_q[0];
        end else if (last_byte) begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          // next byte starts right after the stop bit
          bit_cnt  <= '0;
          byte_idx <= byte_idx + 1'b1;
          tx       <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd_in;
      frame_q <= first_frame[FRAME_BITS-1:1];
    end else if (baud_tick) begin
      if (!frame_end) begin
        frame_q <= {1'b1, frame_q[FRAME_BITS-2:1]};
      end else begin
        cmd_q   <= cmd_q << DW;
        frame_q <= next_frame[FRAME_BITS-1:1];
      end
    end
  end

  // idle line while waiting for a command
  assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  // ready comes back only after the last stop bit
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> $past(frame_end && last_byte))
    else $error("cmd_rdy rose inside a frame");

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

  // frame and command geometry
  localparam int DATA_BITS = 8;
  localparam int CMD_BYTES = 2;
  localparam int CMD_WIDTH = CMD_BYTES * DATA_BITS;

  // host command, hi byte goes out first
  typedef struct packed {
    logic [DATA_BITS-1:0] hi;
    logic [DATA_BITS-1:0] lo;
  } cmd_word_t;

  // received byte with its parity flag on top
  typedef struct packed {
    logic                 parity_err;
    logic [DATA_BITS-1:0] data;
  } rx_byte_t;

  // parity bit that makes data plus parity hold an odd count of ones
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    return ~^data;
  endfunction

endpackage
